//--- cpuTop.f
source/cpuPkg.sv
source/ctrlBus.sv
source/arithUnit.sv
source/logicShiftUnit.sv
source/controlUnit.sv
source/datapath.sv
source/cpuTop.sv
dv/wbMemoryModel.sv
dv/cpuTopTb.sv

//--- run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTopTb \
	-f cpuTop.f -o cpuTopSim > build.log 2>&1 \
	&& ./obj_dir/cpuTopSim > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"
grep -q "^RESULT: PASS$" sim.log 2>/dev/null \
	&& echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }

//--- dv/cpuTopTb.sv
`timescale 1ns/1ns

module cpuTopTb;
	import cpuPkg::*;

	localparam word_t ResetPc = 32'h10;
	localparam word_t InValue = 32'h5A3C_96E1;

	logic Clock;
	logic Reset;
	word_t inPort;
	word_t memData;
	word_t cpuData;
	word_t adr;
	word_t outPort;
	logic ack;
	logic cyc;
	logic stb;
	logic we;
	logic outValid;
	logic run;

	// software model state
	word_t rf [16];
	word_t dataMem [word_t];
	word_t prog [$];
	logic skipNext;
	word_t expOut [64];
	word_t expStAdr [8];
	word_t expStDat [8];
	int outCount;
	int stCount;
	int groupEnd [4];
	string groupName [4];

	int outIdx;
	int stIdx;
	int grp;
	int checks;
	int errors;
	logic cycSeen;

	cpuTop #(
		.ResetPc(ResetPc)
	) u_dut (
		.Clock(Clock),
		.Reset(Reset),
		.inPort(inPort),
		.datI(memData),
		.ack(ack),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datO(cpuData),
		.outPort(outPort),
		.outValid(outValid),
		.run(run)
	);

	wbMemoryModel u_mem (
		.Clock(Clock),
		.Reset(Reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datW(cpuData),
		.datR(memData),
		.ack(ack)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// assembles one instruction and applies it to the model
	task automatic exec(input opcode_t op, input int ra, input int rb, input int rc,
		input int c);
		word_t w;
		word_t base;
		word_t cw;
		logic taken;
		cw = word_t'(c);
		base = (rb == 0) ? '0 : rf[rb];
		case (op)
			OpBr: w = {op, ra[3:0], 2'b00, rc[1:0], c[18:0]};
			OpAdd, OpSub, OpAnd, OpOr, OpShl, OpShr: w = {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
			default: w = {op, ra[3:0], rb[3:0], c[18:0]};
		endcase
		prog.push_back(w);
		if (skipNext) begin
			skipNext = 1'b0;
			return;
		end
		case (op)
			OpAdd: rf[ra] = rf[rb] + rf[rc];
			OpSub: rf[ra] = rf[rb] - rf[rc];
			OpAnd: rf[ra] = rf[rb] & rf[rc];
			OpOr: rf[ra] = rf[rb] | rf[rc];
			OpShl: rf[ra] = rf[rb] << rf[rc][4:0];
			OpShr: rf[ra] = rf[rb] >> rf[rc][4:0];
			OpNeg: rf[ra] = -rf[rb];
			OpNot: rf[ra] = ~rf[rb];
			OpAddi: rf[ra] = rf[rb] + cw;
			OpAndi: rf[ra] = rf[rb] & cw;
			OpOri: rf[ra] = rf[rb] | cw;
			OpLdi: rf[ra] = base + cw;
			OpLd: rf[ra] = dataMem[base + cw];
			OpSt: begin
				dataMem[base + cw] = rf[ra];
				expStAdr[stCount] = base + cw;
				expStDat[stCount] = rf[ra];
				stCount++;
			end
			OpIn: rf[ra] = InValue;
			OpOut: begin
				expOut[outCount] = rf[ra];
				outCount++;
			end
			OpBr: begin
				case (rc[1:0])
					2'd0: taken = (rf[ra] == '0);
					2'd1: taken = (rf[ra] != '0);
					2'd2: taken = !rf[ra][31] && (rf[ra] != '0);
					default: taken = rf[ra][31];
				endcase
				skipNext = taken;
			end
			default: ;
		endcase
	endtask

	task automatic buildProgram();
		int takenReg [4];
		int otherReg [4];
		takenReg = '{12, 13, 13, 14};
		otherReg = '{13, 12, 14, 13};
		exec(OpLdi, 1, 0, 0, 25);
		exec(OpLdi, 2, 0, 0, -7);
		exec(OpLdi, 3, 0, 0, 3);
		exec(OpAdd, 4, 1, 2, 0);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpSub, 4, 1, 2, 0);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpAnd, 4, 1, 2, 0);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpOr, 4, 1, 2, 0);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpShl, 4, 1, 3, 0);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpShr, 4, 2, 3, 0);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpNeg, 4, 2, 0, 0);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpNot, 4, 1, 0, 0);
		exec(OpOut, 4, 0, 0, 0);
		groupEnd[0] = outCount;
		exec(OpAddi, 4, 1, 0, -30);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpAddi, 4, 1, 0, 100);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpAndi, 4, 2, 0, -16);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpAndi, 4, 2, 0, 'h3F);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpOri, 4, 1, 0, -256);
		exec(OpOut, 4, 0, 0, 0);
		exec(OpOri, 4, 1, 0, 'h700);
		exec(OpOut, 4, 0, 0, 0);
		groupEnd[1] = outCount;
		// based and absolute addressing, data kept above the program
		exec(OpLdi, 5, 0, 0, 200);
		exec(OpLdi, 6, 0, 0, 'h1234);
		exec(OpSt, 6, 5, 0, 4);
		exec(OpLd, 7, 5, 0, 4);
		exec(OpOut, 7, 0, 0, 0);
		exec(OpSt, 2, 0, 0, 210);
		exec(OpLd, 7, 0, 0, 210);
		exec(OpOut, 7, 0, 0, 0);
		exec(OpLdi, 9, 1, 0, 5);
		exec(OpOut, 9, 0, 0, 0);
		exec(OpIn, 8, 0, 0, 0);
		exec(OpOut, 8, 0, 0, 0);
		groupEnd[2] = outCount;
		exec(OpLdi, 12, 0, 0, 0);
		exec(OpLdi, 13, 0, 0, 5);
		exec(OpLdi, 14, 0, 0, -3);
		// each condition taken over a bad out, then not taken
		for (int cond = 0; cond < 4; cond++) begin
			exec(OpBr, takenReg[cond], 0, cond, 1);
			exec(OpOut, 1, 0, 0, 0);
			exec(OpBr, otherReg[cond], 0, cond, 1);
			exec(OpOut, 2, 0, 0, 0);
			exec(OpOut, 13, 0, 0, 0);
		end
		groupEnd[3] = outCount;
		exec(OpNop, 0, 0, 0, 0);
		exec(OpHalt, 0, 0, 0, 0);
	endtask

	always @(posedge Clock) begin
		if (!Reset && outValid) begin
			outIdx <= outIdx + 1;
			checks++;
			if (grp < 4 && outIdx + 1 == groupEnd[grp]) begin
				$display("test %0d %s: done, errors so far %0d", grp + 2, groupName[grp], errors);
				grp++;
			end
		end
		if (!Reset && cyc) begin
			cycSeen <= 1'b1;
		end
		if (!Reset && cyc && we && ack) begin
			stIdx <= stIdx + 1;
			checks++;
		end
	end

	assert property (@(posedge Clock) disable iff (Reset) cyc && !cycSeen |-> adr == ResetPc)
		else begin
			$display("CHECK FAILED at %0t: adr = %h, expected %h", $time, $sampled(adr), ResetPc);
			errors++;
		end

	assert property (@(posedge Clock) disable iff (Reset) outValid |-> outIdx < outCount)
		else begin
			$display("outPort produced more values than the program emits at %0t", $time);
			errors++;
		end

	assert property (@(posedge Clock) disable iff (Reset)
		outValid && outIdx < outCount |-> outPort == expOut[outIdx])
		else begin
			$display("CHECK FAILED at %0t: outPort = %h, expected %h", $time,
				$sampled(outPort), expOut[$sampled(outIdx)]);
			errors++;
		end

	assert property (@(posedge Clock) disable iff (Reset)
		cyc && we && ack |-> stIdx < stCount && adr == expStAdr[stIdx])
		else begin
			$display("CHECK FAILED at %0t: adr = %h, expected %h", $time,
				$sampled(adr), expStAdr[$sampled(stIdx)]);
			errors++;
		end

	assert property (@(posedge Clock) disable iff (Reset)
		cyc && we && ack && stIdx < stCount |-> cpuData == expStDat[stIdx])
		else begin
			$display("CHECK FAILED at %0t: datO = %h, expected %h", $time,
				$sampled(cpuData), expStDat[$sampled(stIdx)]);
			errors++;
		end

	// halted machine stays off the bus
	assert property (@(posedge Clock) disable iff (Reset) !run |-> !cyc)
		else begin
			$display("bus cycle started after halt at %0t", $time);
			errors++;
		end

	// budget of 40 cycles per instruction
	initial begin
		#1;
		repeat (prog.size() * 40) @(posedge Clock);
		$display("timeout: run still high after %0d cycles", prog.size() * 40);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		Reset = 1'b1;
		inPort = '0;
		skipNext = 1'b0;
		outCount = 0;
		stCount = 0;
		outIdx = 0;
		stIdx = 0;
		grp = 0;
		checks = 0;
		errors = 0;
		cycSeen = 1'b0;
		groupName = '{"register ALU ops", "immediate ops", "load, store and ports", "branches"};
		for (int i = 0; i < 16; i++) begin
			rf[i] = '0;
		end
		buildProgram();
		@(posedge Clock);
		for (int i = 0; i < prog.size(); i++) begin
			u_mem.mem[ResetPc + i] = prog[i];
		end
		repeat (3) @(posedge Clock);
		#1;
		Reset = 1'b0;
		inPort = InValue;
		checks++;
		assert (!cyc && !stb && !we && !outValid && run)
			else begin
				$display("CHECK FAILED at %0t: cyc stb we outValid run = %b%b%b%b%b, expected 00001",
					$time, cyc, stb, we, outValid, run);
				errors++;
			end
		$display("test 1 reset state: done, errors so far %0d", errors);
		wait (!run);
		repeat (20) @(posedge Clock);
		if (outIdx != outCount || stIdx != stCount) begin
			$display("only %0d of %0d outputs and %0d of %0d stores were seen",
				outIdx, outCount, stIdx, stCount);
			errors++;
		end
		$display("test 6 wait states and halt: done, errors so far %0d", errors);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- dv/wbMemoryModel.sv
`timescale 1ns/1ns

module wbMemoryModel #(
	parameter int Depth = 256
) (
	input logic Clock,
	input logic Reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input cpuPkg::word_t adr,
	input cpuPkg::word_t datW,
	output cpuPkg::word_t datR,
	output logic ack
);
	import cpuPkg::*;

	word_t mem [Depth];
	int seed;
	int waitLeft;
	logic pending;

	initial begin
		seed = 71364;
		// fill depends on every address bit
		for (int i = 0; i < Depth; i++) begin
			mem[i] = 32'hE000_0000 ^ (i * 32'h0001_0001);
		end
	end

	// registered ack, at least one wait state plus 0..3 random ones
	always @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			ack <= 1'b0;
			pending <= 1'b0;
			waitLeft <= 0;
			datR <= '0;
		end else if (ack) begin
			ack <= 1'b0;
			pending <= 1'b0;
		end else if (cyc && stb) begin
			if (!pending) begin
				pending <= 1'b1;
				waitLeft <= $random(seed) & 3;
			end else if (waitLeft == 0) begin
				ack <= 1'b1;
				if (we) begin
					mem[adr[7:0]] = datW;
				end else begin
					datR <= mem[adr[7:0]];
				end
			end else begin
				waitLeft <= waitLeft - 1;
			end
		end
	end

endmodule

//--- source/cpuTop.sv
`timescale 1ns/1ns

module cpuTop #(
	parameter cpuPkg::word_t ResetPc = '0
) (
	input logic Clock,
	input logic Reset,
	input cpuPkg::word_t inPort,
	input cpuPkg::word_t datI,
	input logic ack,
	output logic cyc,
	output logic stb,
	output logic we,
	output cpuPkg::word_t adr,
	output cpuPkg::word_t datO,
	output cpuPkg::word_t outPort,
	output logic outValid,
	output logic run
);

	ctrlBus bus ();

	controlUnit u_controlUnit (
		.Clock(Clock),
		.Reset(Reset),
		.bus(bus.control)
	);

	datapath #(
		.ResetPc(ResetPc)
	) u_datapath (
		.Clock(Clock),
		.Reset(Reset),
		.bus(bus.datapath),
		.inPort(inPort),
		.outPort(outPort),
		.outValid(outValid),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datO(datO),
		.datI(datI),
		.ack(ack)
	);

	// low once halt is reached
	assign run = bus.run;

endmodule

//--- source/datapath.sv
`timescale 1ns/1ns

module datapath #(
	parameter cpuPkg::word_t ResetPc = '0
) (
	input logic Clock,
	input logic Reset,
	ctrlBus.datapath bus,
	input cpuPkg::word_t inPort,
	output cpuPkg::word_t outPort,
	output logic outValid,
	output logic cyc,
	output logic stb,
	output logic we,
	output cpuPkg::word_t adr,
	output cpuPkg::word_t datO,
	input cpuPkg::word_t datI,
	input logic ack
);
	import cpuPkg::*;

	word_t regFile [2**RegIdxWidth];
	word_t pc;
	word_t irReg;
	word_t mar;
	word_t mdr;
	word_t y;
	word_t z;
	logic conReg;

	word_t busValue;
	word_t regValue;
	word_t arithResult;
	word_t logicResult;
	word_t aluResult;
	regIdx_t regIdx;
	logic condMet;

	always_comb begin
		if (bus.selA) begin
			regIdx = getRa(irReg);
		end else if (bus.selB) begin
			regIdx = getRb(irReg);
		end else begin
			regIdx = getRc(irReg);
		end
	end

	assign regValue = (bus.baOut && regIdx == '0) ? '0 : regFile[regIdx];

	// the single internal bus
	always_comb begin
		if (bus.regOut || bus.baOut) begin
			busValue = regValue;
		end else if (bus.pcOut) begin
			busValue = pc;
		end else if (bus.mdrOut) begin
			busValue = mdr;
		end else if (bus.zOut) begin
			busValue = z;
		end else if (bus.cOut) begin
			busValue = getConst(irReg);
		end else if (bus.inPortOut) begin
			busValue = inPort;
		end else begin
			busValue = '0;
		end
	end

	arithUnit u_arithUnit (
		.a(y),
		.b(busValue),
		.op(bus.aluOp),
		.result(arithResult)
	);

	logicShiftUnit u_logicShiftUnit (
		.a(y),
		.b(busValue),
		.op(bus.aluOp),
		.result(logicResult)
	);

	assign aluResult = (bus.aluOp inside {AluAdd, AluSub, AluNeg}) ? arithResult : logicResult;

	// R[ra] is on the bus when conIn is set
	always_comb begin
		case (getCond(irReg))
			2'd0: condMet = (busValue == '0);
			2'd1: condMet = (busValue != '0);
			2'd2: condMet = !busValue[WordWidth-1] && (busValue != '0);
			default: condMet = busValue[WordWidth-1];
		endcase
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < 2**RegIdxWidth; i++) begin
				regFile[i] <= '0;
			end
		end else if (bus.regIn) begin
			regFile[regIdx] <= busValue;
		end
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			pc <= ResetPc;
			irReg <= '0;
			mar <= '0;
			mdr <= '0;
			y <= '0;
			z <= '0;
			conReg <= 1'b0;
			outPort <= '0;
			outValid <= 1'b0;
		end else begin
			if (bus.incPc) begin
				pc <= pc + word_t'(1);
			end else if (bus.pcIn) begin
				pc <= busValue;
			end
			if (bus.irIn) begin
				irReg <= busValue;
			end
			if (bus.marIn) begin
				mar <= busValue;
			end
			// read data lands on ack
			if (bus.memRead && ack) begin
				mdr <= datI;
			end else if (bus.mdrIn) begin
				mdr <= busValue;
			end
			if (bus.yIn) begin
				y <= busValue;
			end
			if (bus.zIn) begin
				z <= aluResult;
			end
			if (bus.conIn) begin
				conReg <= condMet;
			end
			if (bus.outPortIn) begin
				outPort <= busValue;
			end
			outValid <= bus.outPortIn;
		end
	end

	// decode sees the word while IR is loading
	assign bus.ir = bus.irIn ? busValue : irReg;
	assign bus.conFlag = conReg;
	assign bus.memDone = ack;

	assign cyc = bus.memRead || bus.memWrite;
	assign stb = cyc;
	assign we = bus.memWrite;
	assign adr = bus.marIn ? busValue : mar;
	assign datO = mdr;

	assert property (@(posedge Clock) disable iff (Reset)
		$onehot0({bus.regOut, bus.baOut, bus.pcOut, bus.mdrOut, bus.zOut, bus.cOut,
			bus.inPortOut}))
		else $error("datapath: more than one bus source");

	// an open cycle keeps its request until ack
	assert property (@(posedge Clock) disable iff (Reset)
		cyc && !ack |=> cyc && we == $past(we) && adr == $past(adr))
		else $error("datapath: Wishbone request changed before ack");

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
	input logic Clock,
	input logic Reset,
	ctrlBus.control bus
);
	import cpuPkg::*;

	typedef enum logic [4:0] {
		ResetState,
		Fetch0,
		Fetch1,
		Fetch2,
		ReadB,
		ReadC,
		ConstC,
		Unary,
		BaseB,
		AddrC,
		WriteZ,
		LdMem,
		LdWrite,
		StMdr,
		StMem,
		BrCon,
		BrPc,
		BrAdd,
		BrWrite,
		InExec,
		OutExec,
		NopExec,
		Halt
	} state_t;

	state_t state;
	state_t nextState;
	opcode_t op;

	// first execute state per opcode, Fetch0 for anything unknown
	function automatic state_t firstState(opcode_t code);
		case (code)
			OpAdd, OpSub, OpAnd, OpOr, OpShl, OpShr: return ReadB;
			OpAddi, OpAndi, OpOri: return ReadB;
			OpNeg, OpNot: return Unary;
			OpLd, OpLdi, OpSt: return BaseB;
			OpBr: return BrCon;
			OpIn: return InExec;
			OpOut: return OutExec;
			OpNop: return NopExec;
			OpHalt: return Halt;
			default: return Fetch0;
		endcase
	endfunction

	function automatic aluOp_t aluFor(opcode_t code);
		case (code)
			OpSub: return AluSub;
			OpNeg: return AluNeg;
			OpAnd, OpAndi: return AluAnd;
			OpOr, OpOri: return AluOr;
			OpNot: return AluNot;
			OpShl: return AluShl;
			OpShr: return AluShr;
			default: return AluAdd;
		endcase
	endfunction

	// ir is forwarded from the bus during fetch2
	assign op = getOp(bus.ir);

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			state <= ResetState;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			ResetState: nextState = Fetch0;
			Fetch0: nextState = Fetch1;
			Fetch1: nextState = bus.memDone ? Fetch2 : Fetch1;
			Fetch2: nextState = firstState(op);
			ReadB: nextState = (op inside {OpAddi, OpAndi, OpOri}) ? ConstC : ReadC;
			ReadC: nextState = WriteZ;
			ConstC: nextState = WriteZ;
			Unary: nextState = WriteZ;
			BaseB: nextState = AddrC;
			AddrC: begin
				if (op == OpLd) begin
					nextState = LdMem;
				end else if (op == OpSt) begin
					nextState = StMdr;
				end else begin
					nextState = WriteZ;
				end
			end
			LdMem: nextState = bus.memDone ? LdWrite : LdMem;
			StMdr: nextState = StMem;
			StMem: nextState = bus.memDone ? Fetch0 : StMem;
			BrCon: nextState = BrPc;
			BrPc: nextState = BrAdd;
			BrAdd: nextState = BrWrite;
			Halt: nextState = Halt;
			default: nextState = Fetch0;
		endcase
	end

	always_comb begin
		bus.regIn = 1'b0;
		bus.regOut = 1'b0;
		bus.baOut = 1'b0;
		bus.selA = 1'b0;
		bus.selB = 1'b0;
		bus.selC = 1'b0;
		bus.pcIn = 1'b0;
		bus.irIn = 1'b0;
		bus.marIn = 1'b0;
		bus.mdrIn = 1'b0;
		bus.yIn = 1'b0;
		bus.zIn = 1'b0;
		bus.outPortIn = 1'b0;
		bus.conIn = 1'b0;
		bus.pcOut = 1'b0;
		bus.mdrOut = 1'b0;
		bus.zOut = 1'b0;
		bus.cOut = 1'b0;
		bus.inPortOut = 1'b0;
		bus.incPc = 1'b0;
		bus.aluOp = aluFor(op);
		bus.memRead = 1'b0;
		bus.memWrite = 1'b0;
		bus.run = 1'b1;
		case (state)
			Fetch0: begin
				bus.pcOut = 1'b1;
				bus.marIn = 1'b1;
				bus.incPc = 1'b1;
			end
			Fetch1: bus.memRead = 1'b1;
			Fetch2: begin
				bus.mdrOut = 1'b1;
				bus.irIn = 1'b1;
			end
			ReadB: begin
				bus.selB = 1'b1;
				bus.regOut = 1'b1;
				bus.yIn = 1'b1;
			end
			ReadC: begin
				bus.selC = 1'b1;
				bus.regOut = 1'b1;
				bus.zIn = 1'b1;
			end
			ConstC: begin
				bus.cOut = 1'b1;
				bus.zIn = 1'b1;
			end
			Unary: begin
				bus.selB = 1'b1;
				bus.regOut = 1'b1;
				bus.zIn = 1'b1;
			end
			// R[rb] with register 0 read as zero
			BaseB: begin
				bus.selB = 1'b1;
				bus.baOut = 1'b1;
				bus.yIn = 1'b1;
			end
			AddrC: begin
				bus.cOut = 1'b1;
				bus.aluOp = AluAdd;
				bus.zIn = 1'b1;
			end
			WriteZ: begin
				bus.zOut = 1'b1;
				bus.selA = 1'b1;
				bus.regIn = 1'b1;
			end
			LdMem: begin
				bus.zOut = 1'b1;
				bus.marIn = 1'b1;
				bus.memRead = 1'b1;
			end
			LdWrite: begin
				bus.mdrOut = 1'b1;
				bus.selA = 1'b1;
				bus.regIn = 1'b1;
			end
			StMdr: begin
				bus.selA = 1'b1;
				bus.regOut = 1'b1;
				bus.mdrIn = 1'b1;
			end
			StMem: begin
				bus.zOut = 1'b1;
				bus.marIn = 1'b1;
				bus.memWrite = 1'b1;
			end
			BrCon: begin
				bus.selA = 1'b1;
				bus.regOut = 1'b1;
				bus.conIn = 1'b1;
			end
			BrPc: begin
				bus.pcOut = 1'b1;
				bus.yIn = 1'b1;
			end
			BrAdd: begin
				bus.cOut = 1'b1;
				bus.aluOp = AluAdd;
				bus.zIn = 1'b1;
			end
			// target only taken when the condition held
			BrWrite: begin
				bus.zOut = 1'b1;
				bus.pcIn = bus.conFlag;
			end
			InExec: begin
				bus.inPortOut = 1'b1;
				bus.selA = 1'b1;
				bus.regIn = 1'b1;
			end
			OutExec: begin
				bus.selA = 1'b1;
				bus.regOut = 1'b1;
				bus.outPortIn = 1'b1;
			end
			Halt: bus.run = 1'b0;
			default: ;
		endcase
	end

	assert property (@(posedge Clock) disable iff (Reset)
		!(bus.memRead && bus.memWrite))
		else $error("controlUnit: read and write requested together");

	// word decoded in fetch2 must be a real instruction
	assert property (@(posedge Clock) disable iff (Reset)
		state == Fetch2 |-> firstState(op) != Fetch0)
		else $error("controlUnit: unknown opcode %0d decoded", op);

endmodule

//--- source/logicShiftUnit.sv
`timescale 1ns/1ns

module logicShiftUnit (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t op,
	output cpuPkg::word_t result
);
	import cpuPkg::*;

	logic [4:0] shamt;

	// only the low five bits count as a shift amount
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			AluAnd: result = a & b;
			AluOr: result = a | b;
			AluNot: result = ~b;
			AluShl: result = a << shamt;
			AluShr: result = a >> shamt;
			default: result = '0;
		endcase
	end

endmodule

//--- source/arithUnit.sv
`timescale 1ns/1ns

module arithUnit (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t op,
	output cpuPkg::word_t result
);
	import cpuPkg::*;

	// a is Y, b is the bus value
	always_comb begin
		case (op)
			AluAdd: result = a + b;
			AluSub: result = a - b;
			AluNeg: result = '0 - b;
			default: result = '0;
		endcase
	end

endmodule

//--- source/ctrlBus.sv
`timescale 1ns/1ns

interface ctrlBus;
	import cpuPkg::*;

	// register file access
	logic regIn;
	logic regOut;
	logic baOut;
	logic selA;
	logic selB;
	logic selC;

	// load enables
	logic pcIn;
	logic irIn;
	logic marIn;
	logic mdrIn;
	logic yIn;
	logic zIn;
	logic outPortIn;
	logic conIn;

	// bus sources
	logic pcOut;
	logic mdrOut;
	logic zOut;
	logic cOut;
	logic inPortOut;

	logic incPc;
	aluOp_t aluOp;
	logic memRead;
	logic memWrite;
	logic run;

	// status back to control
	word_t ir;
	logic conFlag;
	logic memDone;

	modport control (
		output regIn, regOut, baOut, selA, selB, selC,
		output pcIn, irIn, marIn, mdrIn, yIn, zIn, outPortIn, conIn,
		output pcOut, mdrOut, zOut, cOut, inPortOut,
		output incPc, aluOp, memRead, memWrite, run,
		input ir, conFlag, memDone
	);

	modport datapath (
		input regIn, regOut, baOut, selA, selB, selC,
		input pcIn, irIn, marIn, mdrIn, yIn, zIn, outPortIn, conIn,
		input pcOut, mdrOut, zOut, cOut, inPortOut,
		input incPc, aluOp, memRead, memWrite,
		output ir, conFlag, memDone
	);

endinterface

//--- source/cpuPkg.sv
package cpuPkg;

	localparam int WordWidth = 32;
	localparam int RegIdxWidth = 4;

	typedef logic [WordWidth-1:0] word_t;
	typedef logic [RegIdxWidth-1:0] regIdx_t;

	typedef enum logic [4:0] {
		OpLd = 5'd0,
		OpLdi = 5'd1,
		OpSt = 5'd2,
		OpAdd = 5'd3,
		OpSub = 5'd4,
		OpShr = 5'd5,
		OpShl = 5'd6,
		OpAnd = 5'd9,
		OpOr = 5'd10,
		OpAddi = 5'd11,
		OpAndi = 5'd12,
		OpOri = 5'd13,
		OpNeg = 5'd16,
		OpNot = 5'd17,
		OpBr = 5'd18,
		OpIn = 5'd21,
		OpOut = 5'd22,
		OpNop = 5'd25,
		OpHalt = 5'd26
	} opcode_t;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluNeg,
		AluAnd,
		AluOr,
		AluNot,
		AluShl,
		AluShr
	} aluOp_t;

	// instruction field positions
	localparam int OpLsb = 27;
	localparam int RaLsb = 23;
	localparam int RbLsb = 19;
	localparam int RcLsb = 15;
	localparam int ConstWidth = 19;
	localparam int CondLsb = 19;

	function automatic opcode_t getOp(word_t w);
		return opcode_t'(w[WordWidth-1:OpLsb]);
	endfunction

	function automatic regIdx_t getRa(word_t w);
		return w[RaLsb +: RegIdxWidth];
	endfunction

	function automatic regIdx_t getRb(word_t w);
		return w[RbLsb +: RegIdxWidth];
	endfunction

	function automatic regIdx_t getRc(word_t w);
		return w[RcLsb +: RegIdxWidth];
	endfunction

	// C sign-extended to a full word
	function automatic word_t getConst(word_t w);
		return {{(WordWidth-ConstWidth){w[ConstWidth-1]}}, w[ConstWidth-1:0]};
	endfunction

	function automatic logic [1:0] getCond(word_t w);
		return w[CondLsb +: 2];
	endfunction

endpackage
